// ==== hdl/mem_stage_pkg.sv ====
// memory-access stage types: word, register address, byte select, op code
// kept operation codes, lane masks and the writeback source enum
`default_nettype none

package mem_stage_pkg;

    typedef logic [31:0] word_t;      // data, address, register value
    typedef logic [4:0]  reg_addr_t;  // destination register number
    typedef logic [3:0]  byte_sel_t;  // bit 3 = msb lane
    typedef logic [7:0]  mem_op_t;    // aluop from execute

    // operation codes as the execute stage issues them
    localparam mem_op_t MEM_OP_NOP = 8'b0000_0000;
    localparam mem_op_t MEM_OP_LB  = 8'b1110_0000;
    localparam mem_op_t MEM_OP_LBU = 8'b1110_0100;
    localparam mem_op_t MEM_OP_LH  = 8'b1110_0001;
    localparam mem_op_t MEM_OP_LHU = 8'b1110_0101;
    localparam mem_op_t MEM_OP_LW  = 8'b1110_0011;
    localparam mem_op_t MEM_OP_SB  = 8'b1110_1000;
    localparam mem_op_t MEM_OP_SH  = 8'b1110_1001;
    localparam mem_op_t MEM_OP_SW  = 8'b1110_1011;
    localparam mem_op_t MEM_OP_LL  = 8'b1111_0000;
    localparam mem_op_t MEM_OP_SC  = 8'b1111_1000;

    // lane masks, big-endian lane order
    localparam byte_sel_t SEL_NONE    = 4'b0000;
    localparam byte_sel_t SEL_BYTE0   = 4'b1000; // offset 0, shifted right per offset
    localparam byte_sel_t SEL_HI_HALF = 4'b1100;
    localparam byte_sel_t SEL_LO_HALF = 4'b0011;
    localparam byte_sel_t SEL_WORD    = 4'b1111;

    localparam word_t SC_OK_WORD   = 32'd1;
    localparam word_t SC_FAIL_WORD = 32'd0;

    // where the register-file write data comes from
    typedef enum logic [2:0] {
        WB_ALU,     // wdata_i as is
        WB_LB,
        WB_LBU,
        WB_LH,
        WB_LHU,
        WB_LW,      // also LL
        WB_SC_OK,
        WB_SC_FAIL
    } wb_src_t;

endpackage

`default_nettype wire

// ==== hdl/mem_bus_if.sv ====
// data-RAM request bundle with driver and observer modports
`default_nettype none
`timescale 1ns/1ps

interface mem_bus_if;
    import mem_stage_pkg::*;

    word_t     addr;
    logic      ce;     // access this cycle
    logic      we;     // write, only lanes in sel
    byte_sel_t sel;
    word_t     wdata;

    modport master (
        output addr, ce, we, sel, wdata
    );

    modport monitor (
        input addr, ce, we, sel, wdata
    );

endinterface

`default_nettype wire

// ==== hdl/mem_access_ctrl.sv ====
// memory operation decode: RAM strobes, byte lanes, store data,
// SC gating against the LLbit and the writeback source
`default_nettype none
`timescale 1ns/1ps

module mem_access_ctrl (
    input  mem_stage_pkg::mem_op_t aluop_i,
    input  mem_stage_pkg::word_t   mem_addr_i,
    input  mem_stage_pkg::word_t   reg2_i,
    input  logic                   llbit_i,
    mem_bus_if.master              bus_o,
    output mem_stage_pkg::wb_src_t wb_src_o,
    output logic                   llbit_we_o,
    output logic                   llbit_value_o
);
    import mem_stage_pkg::*;

    byte_sel_t byte_lane;
    byte_sel_t half_lane;

    assign byte_lane = SEL_BYTE0 >> mem_addr_i[1:0]; // offset n -> lane 3-n

    always_comb begin
        case (mem_addr_i[1:0])
            2'b00:   half_lane = SEL_HI_HALF;
            2'b10:   half_lane = SEL_LO_HALF;
            default: half_lane = SEL_NONE;    // misaligned, no lanes
        endcase
    end

    always_comb begin
        bus_o.addr    = '0;
        bus_o.ce      = 1'b0;
        bus_o.we      = 1'b0;
        bus_o.sel     = SEL_NONE;
        bus_o.wdata   = '0;
        wb_src_o      = WB_ALU;
        llbit_we_o    = 1'b0;
        llbit_value_o = 1'b0;
        case (aluop_i)
            MEM_OP_LB, MEM_OP_LBU: begin
                bus_o.addr = mem_addr_i;
                bus_o.ce   = 1'b1;
                bus_o.sel  = byte_lane;
                wb_src_o   = (aluop_i == MEM_OP_LB) ? WB_LB : WB_LBU;
            end
            MEM_OP_LH, MEM_OP_LHU: begin
                bus_o.addr = mem_addr_i;
                bus_o.ce   = 1'b1;               // still strobed when misaligned
                bus_o.sel  = half_lane;
                wb_src_o   = (aluop_i == MEM_OP_LH) ? WB_LH : WB_LHU;
            end
            MEM_OP_LW: begin
                bus_o.addr = mem_addr_i;
                bus_o.ce   = 1'b1;
                bus_o.sel  = SEL_WORD;
                wb_src_o   = WB_LW;
            end
            MEM_OP_LL: begin
                bus_o.addr    = mem_addr_i;
                bus_o.ce      = 1'b1;
                bus_o.sel     = SEL_WORD;
                wb_src_o      = WB_LW;
                llbit_we_o    = 1'b1;            // open the reservation
                llbit_value_o = 1'b1;
            end
            MEM_OP_SB: begin
                bus_o.addr  = mem_addr_i;
                bus_o.ce    = 1'b1;
                bus_o.we    = 1'b1;
                bus_o.sel   = byte_lane;
                bus_o.wdata = {4{reg2_i[7:0]}};
            end
            MEM_OP_SH: begin
                bus_o.addr  = mem_addr_i;
                bus_o.ce    = 1'b1;
                bus_o.we    = 1'b1;
                bus_o.sel   = half_lane;
                bus_o.wdata = {2{reg2_i[15:0]}};
            end
            MEM_OP_SW: begin
                bus_o.addr  = mem_addr_i;
                bus_o.ce    = 1'b1;
                bus_o.we    = 1'b1;
                bus_o.sel   = SEL_WORD;
                bus_o.wdata = reg2_i;
            end
            MEM_OP_SC: begin
                if (llbit_i) begin
                    bus_o.addr    = mem_addr_i;
                    bus_o.ce      = 1'b1;
                    bus_o.we      = 1'b1;
                    bus_o.sel     = SEL_WORD;
                    bus_o.wdata   = reg2_i;
                    wb_src_o      = WB_SC_OK;
                    llbit_we_o    = 1'b1;        // reservation consumed
                    llbit_value_o = 1'b0;
                end else begin
                    wb_src_o = WB_SC_FAIL;       // no access at all
                end
            end
            default: begin
                wb_src_o = WB_ALU;               // NOP or non-memory op, pass through
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/wb_data_select.sv ====
// writeback data select: loaded lane with sign or zero extension,
// ALU result, or SC status word
`default_nettype none
`timescale 1ns/1ps

module wb_data_select (
    input  mem_stage_pkg::wb_src_t wb_src_i,
    mem_bus_if.monitor             bus_i,
    input  mem_stage_pkg::word_t   mem_data_i,
    input  mem_stage_pkg::word_t   wdata_i,
    output mem_stage_pkg::word_t   wb_data_o
);
    import mem_stage_pkg::*;

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // lanes follow the selects already driven to the RAM
    always_comb begin
        case (bus_i.sel)
            4'b1000: lane_byte = mem_data_i[31:24];
            4'b0100: lane_byte = mem_data_i[23:16];
            4'b0010: lane_byte = mem_data_i[15:8];
            4'b0001: lane_byte = mem_data_i[7:0];
            default: lane_byte = 8'h00;
        endcase
    end

    always_comb begin
        case (bus_i.sel)
            SEL_HI_HALF: lane_half = mem_data_i[31:16];
            SEL_LO_HALF: lane_half = mem_data_i[15:0];
            default:     lane_half = 16'h0000; // misaligned halfword reads 0
        endcase
    end

    always_comb begin
        case (wb_src_i)
            WB_LB:      wb_data_o = {{24{lane_byte[7]}}, lane_byte};
            WB_LBU:     wb_data_o = {24'h000000, lane_byte};
            WB_LH:      wb_data_o = {{16{lane_half[15]}}, lane_half};
            WB_LHU:     wb_data_o = {16'h0000, lane_half};
            WB_LW:      wb_data_o = mem_data_i;
            WB_SC_OK:   wb_data_o = SC_OK_WORD;
            WB_SC_FAIL: wb_data_o = SC_FAIL_WORD;
            default:    wb_data_o = wdata_i;   // WB_ALU
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/mem_wb_reg.sv ====
// MEM/WB pipeline register and the LLbit flip-flop
`default_nettype none
`timescale 1ns/1ps

module mem_wb_reg (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  mem_stage_pkg::reg_addr_t wd_i,
    input  logic                     wreg_i,
    input  mem_stage_pkg::word_t     wb_data_i,
    input  logic                     llbit_we_i,
    input  logic                     llbit_value_i,
    output mem_stage_pkg::reg_addr_t wb_wd_o,
    output logic                     wb_wreg_o,
    output mem_stage_pkg::word_t     wb_wdata_o,
    output logic                     llbit_o
);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_wd_o    <= '0;
            wb_wreg_o  <= 1'b0;
            wb_wdata_o <= '0;
        end else begin
            wb_wd_o    <= wd_i;
            wb_wreg_o  <= wreg_i;
            wb_wdata_o <= wb_data_i;
        end
    end

    // updated on the same edge as the MEM/WB register,
    // so the next op in MEM already sees the new value
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            llbit_o <= 1'b0;
        end else if (llbit_we_i) begin
            llbit_o <= llbit_value_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mem_stage_top.sv ====
// memory-access stage top: RAM strobes out, MEM/WB register and LLbit
`default_nettype none
`timescale 1ns/1ps

module mem_stage_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  mem_stage_pkg::reg_addr_t wd_i,
    input  logic                     wreg_i,
    input  mem_stage_pkg::word_t     wdata_i,
    input  mem_stage_pkg::mem_op_t   aluop_i,
    input  mem_stage_pkg::word_t     mem_addr_i,
    input  mem_stage_pkg::word_t     reg2_i,
    input  mem_stage_pkg::word_t     mem_data_i,   // same-cycle RAM read data
    output mem_stage_pkg::word_t     mem_addr_o,
    output logic                     mem_ce_o,
    output logic                     mem_we_o,
    output mem_stage_pkg::byte_sel_t mem_sel_o,
    output mem_stage_pkg::word_t     mem_data_o,
    output mem_stage_pkg::reg_addr_t wb_wd_o,
    output logic                     wb_wreg_o,
    output mem_stage_pkg::word_t     wb_wdata_o,
    output logic                     llbit_o
);
    import mem_stage_pkg::*;

    wb_src_t wb_src;
    word_t   wb_data;
    logic    llbit_we;
    logic    llbit_value;

    mem_bus_if u_bus ();

    mem_access_ctrl u_ctrl (
        .aluop_i       (aluop_i),
        .mem_addr_i    (mem_addr_i),
        .reg2_i        (reg2_i),
        .llbit_i       (llbit_o),
        .bus_o         (u_bus.master),
        .wb_src_o      (wb_src),
        .llbit_we_o    (llbit_we),
        .llbit_value_o (llbit_value)
    );

    wb_data_select u_wb_sel (
        .wb_src_i   (wb_src),
        .bus_i      (u_bus.monitor),
        .mem_data_i (mem_data_i),
        .wdata_i    (wdata_i),
        .wb_data_o  (wb_data)
    );

    mem_wb_reg u_mem_wb (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wd_i          (wd_i),
        .wreg_i        (wreg_i),
        .wb_data_i     (wb_data),
        .llbit_we_i    (llbit_we),
        .llbit_value_i (llbit_value),
        .wb_wd_o       (wb_wd_o),
        .wb_wreg_o     (wb_wreg_o),
        .wb_wdata_o    (wb_wdata_o),
        .llbit_o       (llbit_o)
    );

    assign mem_addr_o = u_bus.addr;
    assign mem_ce_o   = u_bus.ce;
    assign mem_we_o   = u_bus.we;
    assign mem_sel_o  = u_bus.sel;
    assign mem_data_o = u_bus.wdata;

endmodule

`default_nettype wire

// ==== verif/mem_stage_checker.sv ====
// bound assertions on the data-RAM strobes of the memory-access stage
`default_nettype none
`timescale 1ns/1ps

module mem_stage_checker (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input mem_stage_pkg::mem_op_t aluop_i,
    input mem_stage_pkg::word_t   mem_addr_i,
    input logic                   ce_i,
    input logic                   we_i,
    input mem_stage_pkg::byte_sel_t sel_i
);
    import mem_stage_pkg::*;

    logic half_op;
    logic misaligned;
    int   fail_cnt = 0;

    assign half_op    = (aluop_i == MEM_OP_LH) || (aluop_i == MEM_OP_LHU) ||
                        (aluop_i == MEM_OP_SH);
    assign misaligned = half_op && mem_addr_i[0];

    a_we_needs_ce: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        we_i |-> ce_i)
        else begin
            fail_cnt++;
            $error("write strobe without chip enable");
        end

    a_nop_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (aluop_i == MEM_OP_NOP) |-> !ce_i)
        else begin
            fail_cnt++;
            $error("chip enable raised for a NOP");
        end

    a_aligned_sel: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (ce_i && !misaligned) |-> (sel_i != 4'b0000))
        else begin
            fail_cnt++;
            $error("aligned access with no byte lanes");
        end

endmodule

`default_nettype wire

// ==== verif/mem_stage_monitor.sv ====
// output checker: RAM strobes in the same cycle, writeback one edge later,
// per-row result lines and a closing count line
`default_nettype none
`timescale 1ns/1ps

module mem_stage_monitor (
    input  logic         clk_i,
    input  logic         chk_valid_i,
    input  logic         chk_reset_i,
    input  logic         report_i,
    input  logic [127:0] exp_name_i,
    input  logic         exp_ce_i,
    input  logic         exp_we_i,
    input  logic [3:0]   exp_sel_i,
    input  logic [31:0]  exp_addr_i,
    input  logic [31:0]  exp_mdata_i,
    input  logic [31:0]  exp_wb_i,
    input  logic [4:0]   exp_wd_i,
    input  logic         exp_wreg_i,
    input  logic         exp_ll_i,
    input  logic [31:0]  mem_addr_i,
    input  logic         mem_ce_i,
    input  logic         mem_we_i,
    input  logic [3:0]   mem_sel_i,
    input  logic [31:0]  mem_data_i,
    input  logic [4:0]   wb_wd_i,
    input  logic         wb_wreg_i,
    input  logic [31:0]  wb_wdata_i,
    input  logic         llbit_i,
    output int           row_cnt_o,
    output int           err_cnt_o
);
    logic         pend_valid = 1'b0;
    logic         pend_bad;
    logic [127:0] pend_name;
    logic [31:0]  pend_wb;
    logic [4:0]   pend_wd;
    logic         pend_wreg;
    logic         pend_ll;

    initial begin
        row_cnt_o = 0;
        err_cnt_o = 0;
    end

    task automatic compare(input logic [127:0] name, input string field,
                           input logic [31:0] exp, input logic [31:0] act,
                           inout logic bad);
        if (exp !== act) begin
            $display("FAIL %0s %0s expected %h actual %h", name, field, exp, act);
            bad = 1'b1;
        end
    endtask

    always @(negedge clk_i) begin
        logic bad;
        if (chk_reset_i) begin
            bad = 1'b0;
            compare("reset_state", "wb_wreg", 32'd0, {31'd0, wb_wreg_i}, bad);
            compare("reset_state", "wb_wd", 32'd0, {27'd0, wb_wd_i}, bad);
            compare("reset_state", "wb_wdata", 32'd0, wb_wdata_i, bad);
            compare("reset_state", "llbit", 32'd0, {31'd0, llbit_i}, bad);
            if (bad) err_cnt_o++;
            else $display("ok   reset_state");
        end
        if (pend_valid) begin           // writeback of the previous row
            bad = pend_bad;
            compare(pend_name, "wb_wdata", pend_wb, wb_wdata_i, bad);
            compare(pend_name, "wb_wd", {27'd0, pend_wd}, {27'd0, wb_wd_i}, bad);
            compare(pend_name, "wb_wreg", {31'd0, pend_wreg}, {31'd0, wb_wreg_i}, bad);
            compare(pend_name, "llbit", {31'd0, pend_ll}, {31'd0, llbit_i}, bad);
            row_cnt_o++;
            if (bad) err_cnt_o++;
            else $display("ok   %0s", pend_name);
        end
        pend_valid = chk_valid_i;
        if (chk_valid_i) begin          // bus side of this row, same cycle
            bad = 1'b0;
            compare(exp_name_i, "ce", {31'd0, exp_ce_i}, {31'd0, mem_ce_i}, bad);
            compare(exp_name_i, "we", {31'd0, exp_we_i}, {31'd0, mem_we_i}, bad);
            compare(exp_name_i, "sel", {28'd0, exp_sel_i}, {28'd0, mem_sel_i}, bad);
            if (exp_ce_i) compare(exp_name_i, "addr", exp_addr_i, mem_addr_i, bad);
            if (exp_we_i) compare(exp_name_i, "store data", exp_mdata_i, mem_data_i, bad);
            pend_bad  = bad;
            pend_name = exp_name_i;
            pend_wb   = exp_wb_i;
            pend_wd   = exp_wd_i;
            pend_wreg = exp_wreg_i;
            pend_ll   = exp_ll_i;
        end
    end

    always @(posedge report_i) begin
        $display("rows checked %0d, rows failed %0d", row_cnt_o, err_cnt_o);
    end

endmodule

`default_nettype wire

// ==== verif/tb_mem_stage.sv ====
// testbench for the memory-access stage: clock, reset, random stimulus table,
// row loop and cycle limit
`default_nettype none
`timescale 1ns/1ps

module tb_mem_stage;
    import mem_stage_pkg::*;

    localparam int MAX_ROWS = 32;
    localparam int RESET_CYCLES = 8;

    logic clk = 1'b0;
    logic rst_n, wreg, we_o, ce_o, wb_wreg, llbit;
    reg_addr_t wd, wb_wd;
    word_t wdata, addr, reg2, mdata, addr_o, data_o, wb_wdata;
    mem_op_t aluop;
    byte_sel_t sel_o;

    logic chk_valid, chk_reset, report, e_ce, e_we, e_wreg, e_ll;
    logic [127:0] e_name;
    logic [3:0] e_sel;
    logic [31:0] e_addr, e_mdata, e_wb;
    logic [4:0] e_wd;
    int row_cnt, err_cnt, n_rows, cyc_cnt, cyc_limit;
    logic ll_model;

    logic [127:0] t_name [MAX_ROWS];
    mem_op_t t_op [MAX_ROWS];
    word_t t_addr [MAX_ROWS], t_reg2 [MAX_ROWS], t_mdata [MAX_ROWS], t_wdata [MAX_ROWS];
    word_t t_store [MAX_ROWS], t_wb [MAX_ROWS];
    reg_addr_t t_wd [MAX_ROWS];
    logic t_wreg [MAX_ROWS], t_ce [MAX_ROWS], t_we [MAX_ROWS], t_ll [MAX_ROWS];
    byte_sel_t t_sel [MAX_ROWS];

    always #5 clk = ~clk;

    mem_stage_top u_dut (
        .clk_i(clk), .rst_n_i(rst_n), .wd_i(wd), .wreg_i(wreg), .wdata_i(wdata),
        .aluop_i(aluop), .mem_addr_i(addr), .reg2_i(reg2), .mem_data_i(mdata),
        .mem_addr_o(addr_o), .mem_ce_o(ce_o), .mem_we_o(we_o), .mem_sel_o(sel_o),
        .mem_data_o(data_o), .wb_wd_o(wb_wd), .wb_wreg_o(wb_wreg),
        .wb_wdata_o(wb_wdata), .llbit_o(llbit)
    );

    mem_stage_monitor u_mon (
        .clk_i(clk), .chk_valid_i(chk_valid), .chk_reset_i(chk_reset), .report_i(report),
        .exp_name_i(e_name), .exp_ce_i(e_ce), .exp_we_i(e_we), .exp_sel_i(e_sel),
        .exp_addr_i(e_addr), .exp_mdata_i(e_mdata), .exp_wb_i(e_wb), .exp_wd_i(e_wd),
        .exp_wreg_i(e_wreg), .exp_ll_i(e_ll), .mem_addr_i(addr_o), .mem_ce_i(ce_o),
        .mem_we_i(we_o), .mem_sel_i(sel_o), .mem_data_i(data_o), .wb_wd_i(wb_wd),
        .wb_wreg_i(wb_wreg), .wb_wdata_i(wb_wdata), .llbit_i(llbit),
        .row_cnt_o(row_cnt), .err_cnt_o(err_cnt)
    );

    bind mem_access_ctrl mem_stage_checker u_chk (
        .clk_i(tb_mem_stage.clk), .rst_n_i(tb_mem_stage.rst_n), .aluop_i(aluop_i),
        .mem_addr_i(mem_addr_i), .ce_i(bus_o.ce), .we_i(bus_o.we), .sel_i(bus_o.sel)
    );

    // expectations follow the lane, extension, store and LL/SC rules
    task automatic add_row(input logic [127:0] name, input mem_op_t op, input logic [1:0] off);
        int i;
        logic [7:0] b;
        logic [15:0] h;
        i = n_rows;
        t_name[i] = name;
        t_op[i] = op;
        t_addr[i] = ({$urandom} & 32'hffff_fffc) | {30'd0, off};
        t_mdata[i] = $urandom | 32'h8080_8080;  // sign bit set in every lane
        t_reg2[i] = $urandom;
        t_wdata[i] = $urandom;
        t_wd[i] = 5'($urandom);
        t_wreg[i] = 1'b1;
        t_ce[i] = 1'b0;
        t_we[i] = 1'b0;
        t_sel[i] = 4'b0000;
        t_store[i] = '0;
        t_wb[i] = t_wdata[i];
        b = t_mdata[i][8*(3-off) +: 8];
        h = (off == 2'd0) ? t_mdata[i][31:16] : (off == 2'd2) ? t_mdata[i][15:0] : 16'h0;
        case (op)
            MEM_OP_LB, MEM_OP_LBU: begin
                t_ce[i] = 1'b1;
                t_sel[i] = 4'b0001 << (3 - off);
                t_wb[i] = (op == MEM_OP_LB) ? {{24{b[7]}}, b} : {24'd0, b};
            end
            MEM_OP_LH, MEM_OP_LHU: begin
                t_ce[i] = 1'b1;
                t_sel[i] = (off == 2'd0) ? 4'b1100 : (off == 2'd2) ? 4'b0011 : 4'b0000;
                t_wb[i] = (op == MEM_OP_LH) ? {{16{h[15]}}, h} : {16'd0, h};
            end
            MEM_OP_LW, MEM_OP_LL: begin
                t_ce[i] = 1'b1;
                t_sel[i] = 4'b1111;
                t_wb[i] = t_mdata[i];
                if (op == MEM_OP_LL) ll_model = 1'b1;
            end
            MEM_OP_SB, MEM_OP_SH, MEM_OP_SW: begin
                t_ce[i] = 1'b1;
                t_we[i] = 1'b1;
                t_wreg[i] = 1'b0;
                if (op == MEM_OP_SB) begin
                    t_sel[i] = 4'b0001 << (3 - off);
                    t_store[i] = {4{t_reg2[i][7:0]}};
                end else if (op == MEM_OP_SH) begin
                    t_sel[i] = (off == 2'd0) ? 4'b1100 : 4'b0011;
                    t_store[i] = {2{t_reg2[i][15:0]}};
                end else begin
                    t_sel[i] = 4'b1111;
                    t_store[i] = t_reg2[i];
                end
            end
            MEM_OP_SC: begin
                t_wb[i] = {31'd0, ll_model};
                if (ll_model) begin
                    t_ce[i] = 1'b1;
                    t_we[i] = 1'b1;
                    t_sel[i] = 4'b1111;
                    t_store[i] = t_reg2[i];
                    ll_model = 1'b0;
                end
            end
            default: ;                      // NOP and ALU ops pass wdata through
        endcase
        t_ll[i] = ll_model;
        n_rows++;
    endtask

    always @(posedge clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (cyc_cnt >= cyc_limit) begin
            $display("timeout: run did not finish within %0d cycles", cyc_limit);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h35f1af16));
        rst_n = 1'b0;
        wd = 5'h1f;                         // busy inputs while reset is held
        wreg = 1'b1;
        wdata = 32'hffff_ffff;
        aluop = MEM_OP_LL;
        addr = '0;
        reg2 = '0;
        mdata = 32'hffff_ffff;
        chk_valid = 1'b0;
        chk_reset = 1'b0;
        report = 1'b0;
        e_name = '0;
        e_ce = 1'b0;
        e_we = 1'b0;
        e_sel = '0;
        e_addr = '0;
        e_mdata = '0;
        e_wb = '0;
        e_wd = '0;
        e_wreg = 1'b0;
        e_ll = 1'b0;
        n_rows = 0;
        cyc_cnt = 0;
        ll_model = 1'b0;
        for (int k = 0; k < 4; k++) add_row("lb", MEM_OP_LB, 2'(k));
        for (int k = 0; k < 4; k++) add_row("lbu", MEM_OP_LBU, 2'(k));
        add_row("lh_off0", MEM_OP_LH, 2'd0);
        add_row("lh_off2", MEM_OP_LH, 2'd2);
        add_row("lhu_off0", MEM_OP_LHU, 2'd0);
        add_row("lhu_off2", MEM_OP_LHU, 2'd2);
        add_row("lh_off1", MEM_OP_LH, 2'd1);
        add_row("lhu_off3", MEM_OP_LHU, 2'd3);
        add_row("lw", MEM_OP_LW, 2'd0);
        add_row("sb_off1", MEM_OP_SB, 2'd1);
        add_row("sb_off3", MEM_OP_SB, 2'd3);
        add_row("sh_off0", MEM_OP_SH, 2'd0);
        add_row("sh_off2", MEM_OP_SH, 2'd2);
        add_row("sw", MEM_OP_SW, 2'd0);
        add_row("sc_no_link", MEM_OP_SC, 2'd0);
        add_row("ll", MEM_OP_LL, 2'd0);
        add_row("sc_linked", MEM_OP_SC, 2'd0);
        add_row("sc_after_sc", MEM_OP_SC, 2'd0);
        add_row("nop", MEM_OP_NOP, 2'd0);
        add_row("alu_pass", 8'h21, 2'd0);
        cyc_limit = n_rows + RESET_CYCLES + 20;

        repeat (RESET_CYCLES - 1) @(posedge clk);
        chk_reset <= 1'b1;                  // sampled while reset is still low
        @(posedge clk);
        chk_reset <= 1'b0;
        rst_n <= 1'b1;
        wd <= '0;
        wreg <= 1'b0;
        wdata <= '0;
        aluop <= MEM_OP_NOP;
        mdata <= '0;
        @(posedge clk);
        for (int i = 0; i < n_rows; i++) begin
            aluop <= t_op[i];
            addr <= t_addr[i];
            reg2 <= t_reg2[i];
            mdata <= t_mdata[i];
            wdata <= t_wdata[i];
            wd <= t_wd[i];
            wreg <= t_wreg[i];
            chk_valid <= 1'b1;
            e_name <= t_name[i];
            e_ce <= t_ce[i];
            e_we <= t_we[i];
            e_sel <= t_sel[i];
            e_addr <= t_addr[i];
            e_mdata <= t_store[i];
            e_wb <= t_wb[i];
            e_wd <= t_wd[i];
            e_wreg <= t_wreg[i];
            e_ll <= t_ll[i];
            @(posedge clk);
        end
        aluop <= MEM_OP_NOP;
        chk_valid <= 1'b0;
        @(negedge clk);                     // last row's writeback
        @(negedge clk);
        report = 1'b1;
        #1;
        if (err_cnt == 0 && row_cnt == n_rows && u_dut.u_ctrl.u_chk.fail_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mem_stage_top.f ====
hdl/mem_stage_pkg.sv
hdl/mem_bus_if.sv
hdl/mem_access_ctrl.sv
hdl/wb_data_select.sv
hdl/mem_wb_reg.sv
hdl/mem_stage_top.sv
verif/mem_stage_checker.sv
verif/mem_stage_monitor.sv
verif/tb_mem_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_mem_stage
FLIST     ?= mem_stage_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
